// ==== design/aimbot_config.svh ====
`ifndef AIMBOT_CONFIG_SVH
`define AIMBOT_CONFIG_SVH

// Display timing in clk cycles and lines.
`define H_ACTIVE          16
`define H_BLANK           32
`define H_TOTAL           (`H_ACTIVE + `H_BLANK)
`define V_ACTIVE          4
`define V_BLANK           2
`define V_TOTAL           (`V_ACTIVE + `V_BLANK)
`define HSYNC_LEN         4                  // Starts one cycle into blanking.
`define VSYNC_LINES       1                  // First blank line.

// Cycles from the first cam1 href rise to display line zero.
`define SYNC_START_DELAY  20

// Line FIFO geometry.
`define FIFO_DEPTH        16
`define FIFO_AW           4

// Frames per buf_tick pulse.
`define TICK_FRAMES       2

`endif

// ==== design/aimbot_pkg.sv ====
`include "aimbot_config.svh"

package aimbot_pkg;

    // One RGB565 pixel, R in the top five bits.
    typedef logic [15:0] pix565_t;

    // One byte off the camera bus.
    typedef logic [7:0] cam_byte_t;

    // Display position counters.
    typedef logic [7:0] hcnt_t;
    typedef logic [7:0] vcnt_t;

    // Extra top bit tells full from empty.
    typedef logic [`FIFO_AW:0] fifo_ptr_t;

    typedef enum logic {
        WAIT_CAM,
        RUN
    } sync_state_t;

endpackage : aimbot_pkg

// ==== design/aimbot_video.sv ====
`timescale 1ns/1ns

module aimbot_video (
    input  logic                  clk       ,
    input  logic                  rst_n     ,

    input  logic                  cam1_href ,
    input  logic                  cam1_pclk ,
    input  aimbot_pkg::cam_byte_t cam1_data ,

    input  logic                  cam2_href ,
    input  logic                  cam2_pclk ,
    input  aimbot_pkg::cam_byte_t cam2_data ,

    output logic                  hdmi_hsync,
    output logic                  hdmi_vsync,
    output logic                  hdmi_de   ,
    output logic [7:0]            hdmi_r    ,
    output logic [7:0]            hdmi_g    ,
    output logic [7:0]            hdmi_b    ,

    output aimbot_pkg::pix565_t   side_pixel,
    output logic                  buf_tick  ,
    output logic                  comb_err
);

    import aimbot_pkg::*;

    pix565_t cam1_pix;
    pix565_t cam2_pix;
    logic    cam1_pix_valid;
    logic    cam2_pix_valid;
    logic    read_en;
    pix565_t comb_pix_1;

    cam_byte_pack u_cam1_pack (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .href     (cam1_href     ),
        .pclk     (cam1_pclk     ),
        .data     (cam1_data     ),
        .pix      (cam1_pix      ),
        .pix_valid(cam1_pix_valid)
    );

    cam_byte_pack u_cam2_pack (
        .clk      (clk           ),
        .rst_n    (rst_n         ),
        .href     (cam2_href     ),
        .pclk     (cam2_pclk     ),
        .data     (cam2_data     ),
        .pix      (cam2_pix      ),
        .pix_valid(cam2_pix_valid)
    );

    // Display timing locks to cam1 only.
    sync_gen u_sync_gen (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .cam_href(cam1_href ),
        .hsync   (hdmi_hsync),
        .vsync   (hdmi_vsync),
        .read_en (read_en   ),
        .data_en (hdmi_de   )
    );

    pixel_combine u_pixel_combine (
        .clk       (clk           ),
        .rst_n     (rst_n         ),
        .pix1_valid(cam1_pix_valid),
        .pix1      (cam1_pix      ),
        .pix2_valid(cam2_pix_valid),
        .pix2      (cam2_pix      ),
        .read_en   (read_en       ),
        .pixel_1   (comb_pix_1    ),
        .pixel_2   (side_pixel    ),
        .error     (comb_err      )
    );

    frame_tick u_buf_tick (
        .clk  (clk       ),
        .rst_n(rst_n     ),
        .trig (hdmi_vsync),
        .tick (buf_tick  )
    );

    // RGB565 to RGB888, low bits zero.
    assign hdmi_r = {comb_pix_1[15:11], 3'b000};
    assign hdmi_g = {comb_pix_1[10:5],  2'b00};
    assign hdmi_b = {comb_pix_1[4:0],   3'b000};

endmodule : aimbot_video

// ==== design/cam_byte_pack.sv ====
`timescale 1ns/1ns

module cam_byte_pack (
    input  logic                  clk      ,
    input  logic                  rst_n    ,
    input  logic                  href     ,
    input  logic                  pclk     ,
    input  aimbot_pkg::cam_byte_t data     ,
    output aimbot_pkg::pix565_t   pix      ,
    output logic                  pix_valid
);

    import aimbot_pkg::*;

    logic      low_phase;                     // Next byte is the low byte.
    cam_byte_t high_byte;
    logic      byte_stb;

    assign byte_stb = href && pclk;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            low_phase <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (!href) begin
                low_phase <= 1'b0;            // Line ended, realign.
            end else if (byte_stb) begin
                low_phase <= !low_phase;
                pix_valid <= low_phase;
            end
        end
    end

    // Payload path.
    always_ff @(posedge clk) begin
        if (byte_stb) begin
            if (!low_phase) begin
                high_byte <= data;
            end else begin
                pix <= {high_byte, data};
            end
        end
    end

endmodule : cam_byte_pack

// ==== design/frame_tick.sv ====
`timescale 1ns/1ns
`include "aimbot_config.svh"

module frame_tick (
    input  logic clk  ,
    input  logic rst_n,
    input  logic trig ,
    output logic tick
);

    localparam int CNT_W = $clog2(`TICK_FRAMES + 1);

    logic             trig_d;
    logic             trig_rise;
    logic [CNT_W-1:0] frame_cnt;
    logic             wrap;

    assign trig_rise = trig && !trig_d;
    assign wrap      = (frame_cnt == CNT_W'(`TICK_FRAMES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trig_d    <= 1'b0;
            frame_cnt <= '0;
            tick      <= 1'b0;
        end else begin
            trig_d <= trig;
            tick   <= trig_rise && wrap;
            if (trig_rise) begin
                frame_cnt <= wrap ? '0 : frame_cnt + 1'b1;
            end
        end
    end

endmodule : frame_tick

// ==== design/pixel_combine.sv ====
`timescale 1ns/1ns
`include "aimbot_config.svh"

module pixel_combine (
    input  logic                clk       ,
    input  logic                rst_n     ,
    input  logic                pix1_valid,
    input  aimbot_pkg::pix565_t pix1      ,
    input  logic                pix2_valid,
    input  aimbot_pkg::pix565_t pix2      ,
    input  logic                read_en   ,
    output aimbot_pkg::pix565_t pixel_1   ,
    output aimbot_pkg::pix565_t pixel_2   ,
    output logic                error
);

    import aimbot_pkg::*;

    localparam int NCAM = 2;

    logic    [NCAM-1:0] wr_valid;
    pix565_t [NCAM-1:0] wr_pix;
    logic    [NCAM-1:0] fault;

    assign wr_valid = {pix2_valid, pix1_valid};
    assign wr_pix   = {pix2, pix1};

    // One line FIFO per camera, both popped by the same read_en.
    for (genvar c = 0; c < NCAM; c++) begin : g_fifo
        pix565_t   mem [`FIFO_DEPTH];
        fifo_ptr_t wr_ptr;
        fifo_ptr_t rd_ptr;
        fifo_ptr_t level;
        logic      full;
        logic      empty;
        logic      push;
        logic      pop;
        pix565_t   rd_q;

        assign level = wr_ptr - rd_ptr;
        assign full  = (level == fifo_ptr_t'(`FIFO_DEPTH));
        assign empty = (level == '0);
        assign push  = wr_valid[c] && !full;
        assign pop   = read_en && !empty;

        // Dropped write or starved read.
        assign fault[c] = (wr_valid[c] && full) || (read_en && empty);

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr[`FIFO_AW-1:0]] <= wr_pix[c];
            end
            if (read_en) begin
                rd_q <= empty ? '0 : mem[rd_ptr[`FIFO_AW-1:0]];   // Black on under-run.
            end
        end
    end

    assign pixel_1 = g_fifo[0].rd_q;
    assign pixel_2 = g_fifo[1].rd_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            error <= 1'b0;
        end else if (|fault) begin
            error <= 1'b1;                    // Sticky.
        end
    end

endmodule : pixel_combine

// ==== design/sync_gen.sv ====
`timescale 1ns/1ns
`include "aimbot_config.svh"

module sync_gen (
    input  logic clk     ,
    input  logic rst_n   ,
    input  logic cam_href,
    output logic hsync   ,
    output logic vsync   ,
    output logic read_en ,
    output logic data_en
);

    import aimbot_pkg::*;

    sync_state_t state;
    logic        href_d;
    logic        href_seen;
    hcnt_t       dly_cnt;
    hcnt_t       h;
    vcnt_t       v;
    logic        line_end;
    logic        frame_end;
    logic        running;
    logic        hsync_q;
    logic        vsync_q;

    assign line_end  = (h == hcnt_t'(`H_TOTAL - 1));
    assign frame_end = (v == vcnt_t'(`V_TOTAL - 1));
    assign running   = (state == RUN);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            href_d <= 1'b0;
        end else begin
            href_d <= cam_href;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= WAIT_CAM;
            href_seen <= 1'b0;
            dly_cnt   <= '0;
            h         <= '0;
            v         <= '0;
        end else begin
            case (state)
                WAIT_CAM: begin
                    if (!href_seen) begin
                        if (cam_href && !href_d) begin
                            href_seen <= 1'b1;    // First camera line.
                            dly_cnt   <= '0;
                        end
                    end else if (dly_cnt == hcnt_t'(`SYNC_START_DELAY - 1)) begin
                        state <= RUN;
                        h     <= '0;
                        v     <= '0;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                RUN: begin
                    if (line_end) begin
                        h <= '0;
                        v <= frame_end ? '0 : v + 1'b1;
                    end else begin
                        h <= h + 1'b1;
                    end
                end
                default: state <= WAIT_CAM;
            endcase
        end
    end

    // read_en leads by one cycle, the FIFO read register eats it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_en <= 1'b0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            data_en <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
        end else begin
            read_en <= running && (h < hcnt_t'(`H_ACTIVE)) && (v < vcnt_t'(`V_ACTIVE));
            hsync_q <= running && (h > hcnt_t'(`H_ACTIVE))
                       && (h <= hcnt_t'(`H_ACTIVE + `HSYNC_LEN));
            vsync_q <= running && (v >= vcnt_t'(`V_ACTIVE))
                       && (v < vcnt_t'(`V_ACTIVE + `VSYNC_LINES));
            data_en <= read_en;
            hsync   <= hsync_q;
            vsync   <= vsync_q;
        end
    end

endmodule : sync_gen

// ==== dv/aimbot_video_tb.sv ====
`timescale 1ns/1ns
`include "aimbot_config.svh"

module aimbot_video_tb;

    import aimbot_pkg::*;

    localparam int NPIX       = 4 * `V_ACTIVE * `H_ACTIVE;
    localparam int NCHECK     = 3 * `V_ACTIVE * `H_ACTIVE;    // Frames 0 to 2.
    localparam int MAX_CYCLES = 4 * `V_TOTAL * `H_TOTAL + 500;

    logic        clk;
    logic        rst_n;
    logic        cam1_href;
    logic        cam1_pclk;
    cam_byte_t   cam1_data;
    logic        cam2_href;
    logic        cam2_pclk;
    cam_byte_t   cam2_data;
    logic        hdmi_hsync;
    logic        hdmi_vsync;
    logic        hdmi_de;
    logic [7:0]  hdmi_r;
    logic [7:0]  hdmi_g;
    logic [7:0]  hdmi_b;
    pix565_t     side_pixel;
    logic        buf_tick;
    logic        comb_err;

    logic [31:0] stim [0:NPIX];                           // Word 0 holds the starve point.
    int          errors = 0;
    int          cycles = 0;
    int          de_count = 0;
    int          de_len = 0;
    int          de_runs_win = 0;
    int          hs_rises_win = 0;
    int          vs_rises = 0;
    logic        de_d = 1'b0;
    logic        hs_d = 1'b0;
    logic        vs_d = 1'b0;
    logic        tick_due = 1'b0;
    logic        exp_tick;
    bit          starving = 1'b0;
    bit          err_seen = 1'b0;
    bit          err_in_starve = 1'b0;
    pix565_t     exp1;
    pix565_t     exp2;
    logic [7:0]  exp_r;
    logic [7:0]  exp_g;
    logic [7:0]  exp_b;

    aimbot_video u_dut (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .cam1_href (cam1_href ),
        .cam1_pclk (cam1_pclk ),
        .cam1_data (cam1_data ),
        .cam2_href (cam2_href ),
        .cam2_pclk (cam2_pclk ),
        .cam2_data (cam2_data ),
        .hdmi_hsync(hdmi_hsync),
        .hdmi_vsync(hdmi_vsync),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    ),
        .side_pixel(side_pixel),
        .buf_tick  (buf_tick  ),
        .comb_err  (comb_err  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // Drives one camera line of 2*H_ACTIVE bytes and its blanking.
    task automatic drive_line(input int frame, input int line, input bit starve2);
        int          b;
        logic [31:0] word;
        starving = starve2;
        for (b = 0; b < `H_TOTAL; b++) begin
            if (b < 2 * `H_ACTIVE) begin
                word = stim[1 + (frame * `V_ACTIVE + line) * `H_ACTIVE + b / 2];
                cam1_href <= 1'b1;
                cam1_data <= b[0] ? word[23:16] : word[31:24];
                cam2_href <= !starve2;
                cam2_data <= b[0] ? word[7:0] : word[15:8];
            end else begin
                cam1_href <= 1'b0;
                cam1_data <= '0;
                cam2_href <= 1'b0;
                cam2_data <= '0;
            end
            cam1_pclk <= 1'b1;                            // Strobes in blanking must be ignored.
            cam2_pclk <= 1'b1;
            @(posedge clk);
        end
        starving = 1'b0;
    endtask

    task automatic drive_idle_line();
        cam1_href <= 1'b0;
        cam1_pclk <= 1'b0;
        cam2_href <= 1'b0;
        cam2_pclk <= 1'b0;
        repeat (`H_TOTAL) @(posedge clk);
    endtask

    // Samples the outputs on the falling edge.
    always @(negedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles.", MAX_CYCLES);
            $display("Errors: %0d", errors + 1);
            $display("Simulation FAILED");
            $finish;
        end else if (rst_n) begin
            exp_tick = tick_due;
            tick_due = 1'b0;
            if (buf_tick !== exp_tick) begin
                log_mismatch($sformatf("buf_tick %b, expected %b", buf_tick, exp_tick));
            end
            if (hdmi_de) begin
                if (de_count < NCHECK) begin
                    exp1 = stim[de_count + 1][31:16];
                    exp2 = stim[de_count + 1][15:0];
                    exp_r = 8'(exp1[15:11]) << 3;
                    exp_g = 8'(exp1[10:5]) << 2;
                    exp_b = 8'(exp1[4:0]) << 3;
                    if (hdmi_r !== exp_r || hdmi_g !== exp_g || hdmi_b !== exp_b) begin
                        log_mismatch($sformatf("pixel %0d rgb %h %h %h, expected %h %h %h",
                                               de_count, hdmi_r, hdmi_g, hdmi_b,
                                               exp_r, exp_g, exp_b));
                    end
                    if (side_pixel !== exp2) begin
                        log_mismatch($sformatf("pixel %0d side_pixel %h, expected %h",
                                               de_count, side_pixel, exp2));
                    end
                end
                de_count++;
                de_len++;
            end else if (de_d) begin
                if (de_len != `H_ACTIVE) begin
                    log_mismatch($sformatf("line had %0d de cycles, expected %0d",
                                           de_len, `H_ACTIVE));
                end
                de_runs_win++;
                de_len = 0;
            end
            if (hdmi_hsync && !hs_d) begin
                hs_rises_win++;
            end
            if (hdmi_vsync && !vs_d) begin
                if (hs_rises_win != ((vs_rises == 0) ? `V_ACTIVE : `V_TOTAL)) begin
                    log_mismatch($sformatf("%0d hsync rises before vsync %0d", hs_rises_win,
                                           vs_rises));
                end
                if (de_runs_win != `V_ACTIVE) begin
                    log_mismatch($sformatf("%0d active lines before vsync %0d, expected %0d",
                                           de_runs_win, vs_rises, `V_ACTIVE));
                end
                vs_rises++;
                tick_due = (vs_rises % `TICK_FRAMES) == 0;
                hs_rises_win = 0;
                de_runs_win = 0;
            end
            if (comb_err && !err_seen) begin
                err_seen = 1'b1;
                if (starving) begin
                    err_in_starve = 1'b1;
                end else begin
                    log_mismatch("comb_err rose outside the starved cam2 line");
                end
            end else if (!comb_err && err_seen) begin
                log_mismatch("comb_err fell after it was set");
            end
            de_d = hdmi_de;
            hs_d = hdmi_hsync;
            vs_d = hdmi_vsync;
        end
    end

    initial begin
        int unsigned gap;
        int          f;
        int          l;
        int          starve_f;
        int          starve_l;
        rst_n     = 1'b0;
        cam1_href = 1'b0;
        cam1_pclk = 1'b0;
        cam1_data = '0;
        cam2_href = 1'b0;
        cam2_pclk = 1'b0;
        cam2_data = '0;
        $readmemh("dv/video_input.txt", stim);
        starve_f = int'(stim[0][15:8]);
        starve_l = int'(stim[0][7:0]);
        void'($urandom(32'h6250));
        gap = $urandom % 16;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if ({hdmi_de, hdmi_hsync, hdmi_vsync, buf_tick, comb_err} !== 5'b0) begin
            log_mismatch($sformatf("after reset de,hs,vs,tick,err = %b, expected all low",
                         {hdmi_de, hdmi_hsync, hdmi_vsync, buf_tick, comb_err}));
        end
        repeat (gap + 1) @(posedge clk);
        for (f = 0; f < 4; f++) begin
            for (l = 0; l < `V_ACTIVE; l++) begin
                drive_line(f, l, (f == starve_f) && (l == starve_l));
            end
            repeat (`V_BLANK) drive_idle_line();
        end
        repeat (4) @(posedge clk);
        if (vs_rises != 4) begin
            log_mismatch($sformatf("vsync rose %0d times, expected 4", vs_rises));
        end
        if (de_count != NPIX) begin
            log_mismatch($sformatf("%0d de cycles in total, expected %0d", de_count, NPIX));
        end
        if (!err_in_starve) begin
            errors++;
            $display("Check failed: comb_err did not rise during the starved cam2 line.");
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : aimbot_video_tb

// ==== dv/video_input.txt ====
// Word 0: cam2 starve point, frame in bits 15:8 and line in bits 7:0.
// Then {cam1, cam2} RGB565 pairs, 8 per line, in frame, line, pixel order.
00000302
00FFF00F 01FEE01F 02FDD02F 03FCC03F 04FBB04F 05FAA05F 06F9906F 07F8807F
08F7708F 09F6609F 0AF550AF 0BF440BF 0CF330CF 0DF220DF 0EF110EF 0FF000FF
10EFF10E 11EEE11E 12EDD12E 13ECC13E 14EBB14E 15EAA15E 16E9916E 17E8817E
18E7718E 19E6619E 1AE551AE 1BE441BE 1CE331CE 1DE221DE 1EE111EE 1FE001FE
20DFF20D 21DEE21D 22DDD22D 23DCC23D 24DBB24D 25DAA25D 26D9926D 27D8827D
28D7728D 29D6629D 2AD552AD 2BD442BD 2CD332CD 2DD222DD 2ED112ED 2FD002FD
30CFF30C 31CEE31C 32CDD32C 33CCC33C 34CBB34C 35CAA35C 36C9936C 37C8837C
38C7738C 39C6639C 3AC553AC 3BC443BC 3CC333CC 3DC223DC 3EC113EC 3FC003FC
40BFF40B 41BEE41B 42BDD42B 43BCC43B 44BBB44B 45BAA45B 46B9946B 47B8847B
48B7748B 49B6649B 4AB554AB 4BB444BB 4CB334CB 4DB224DB 4EB114EB 4FB004FB
50AFF50A 51AEE51A 52ADD52A 53ACC53A 54ABB54A 55AAA55A 56A9956A 57A8857A
58A7758A 59A6659A 5AA555AA 5BA445BA 5CA335CA 5DA225DA 5EA115EA 5FA005FA
609FF609 619EE619 629DD629 639CC639 649BB649 659AA659 66999669 67988679
68977689 69966699 6A9556A9 6B9446B9 6C9336C9 6D9226D9 6E9116E9 6F9006F9
708FF708 718EE718 728DD728 738CC738 748BB748 758AA758 76899768 77888778
78877788 79866798 7A8557A8 7B8447B8 7C8337C8 7D8227D8 7E8117E8 7F8007F8
807FF807 817EE817 827DD827 837CC837 847BB847 857AA857 86799867 87788877
88777887 89766897 8A7558A7 8B7448B7 8C7338C7 8D7228D7 8E7118E7 8F7008F7
906FF906 916EE916 926DD926 936CC936 946BB946 956AA956 96699966 97688976
98677986 99666996 9A6559A6 9B6449B6 9C6339C6 9D6229D6 9E6119E6 9F6009F6
A05FFA05 A15EEA15 A25DDA25 A35CCA35 A45BBA45 A55AAA55 A6599A65 A7588A75
A8577A85 A9566A95 AA555AA5 AB544AB5 AC533AC5 AD522AD5 AE511AE5 AF500AF5
B04FFB04 B14EEB14 B24DDB24 B34CCB34 B44BBB44 B54AAB54 B6499B64 B7488B74
B8477B84 B9466B94 BA455BA4 BB444BB4 BC433BC4 BD422BD4 BE411BE4 BF400BF4
C03FFC03 C13EEC13 C23DDC23 C33CCC33 C43BBC43 C53AAC53 C6399C63 C7388C73
C8377C83 C9366C93 CA355CA3 CB344CB3 CC333CC3 CD322CD3 CE311CE3 CF300CF3
D02FFD02 D12EED12 D22DDD22 D32CCD32 D42BBD42 D52AAD52 D6299D62 D7288D72
D8277D82 D9266D92 DA255DA2 DB244DB2 DC233DC2 DD222DD2 DE211DE2 DF200DF2
E01FFE01 E11EEE11 E21DDE21 E31CCE31 E41BBE41 E51AAE51 E6199E61 E7188E71
E8177E81 E9166E91 EA155EA1 EB144EB1 EC133EC1 ED122ED1 EE111EE1 EF100EF1
F00FFF00 F10EEF10 F20DDF20 F30CCF30 F40BBF40 F50AAF50 F6099F60 F7088F70
F8077F80 F9066F90 FA055FA0 FB044FB0 FC033FC0 FD022FD0 FE011FE0 FF000FF0

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the aimbot video testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module aimbot_video_tb \
    -o aimbot_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

out=$(./obj_dir/aimbot_video_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== sim.f ====
+incdir+design
design/aimbot_pkg.sv
design/cam_byte_pack.sv
design/sync_gen.sv
design/pixel_combine.sv
design/frame_tick.sv
design/aimbot_video.sv
dv/aimbot_video_tb.sv
